// File: logic/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural integer registers
`define RV_NUM_REGS 32

// Data and address width
`define RV_XLEN 32

`endif

// File: logic/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	// Branch offset is scattered over the word
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	// One instruction word, viewed per format
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} rv_instr_u;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    mem_to_reg;
		logic    branch;
		logic    jump;
		logic    link;
	} ctrl_t;

	typedef struct packed {
		logic                read;
		logic                write;
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] wdata;
	} dmem_req_t;

	// One record per retired instruction
	typedef struct packed {
		logic                valid;
		logic [`RV_XLEN-1:0] pc;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] data;
	} commit_t;

endpackage

// File: logic/rv_decode.sv
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rv_decode (
	input  rv_pkg::rv_instr_u   instr_i,
	output rv_pkg::ctrl_t       ctrl_o,
	output logic [`RV_XLEN-1:0] imm_o,
	output logic                illegal_o
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] imm_itype;
	logic [`RV_XLEN-1:0] imm_stype;
	logic [`RV_XLEN-1:0] imm_btype;
	logic [`RV_XLEN-1:0] imm_jtype;

	// Sign extended immediates, one per format
	assign imm_itype = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
	assign imm_stype = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi,
		instr_i.s_fmt.imm_lo};
	assign imm_btype = {{19{instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_12,
		instr_i.b_fmt.imm_11, instr_i.b_fmt.imm_10_5, instr_i.b_fmt.imm_4_1, 1'b0};
	assign imm_jtype = {{11{instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_20,
		instr_i.j_fmt.imm_19_12, instr_i.j_fmt.imm_11, instr_i.j_fmt.imm_10_1, 1'b0};

	always_comb begin
		ctrl_o    = '0;
		imm_o     = '0;
		illegal_o = 1'b0;
		case (instr_i.r_fmt.opcode)
			OP: begin
				ctrl_o.reg_write = 1'b1;
				case ({instr_i.r_fmt.funct7, instr_i.r_fmt.funct3})
					{7'b0000000, 3'b000}: ctrl_o.alu_op = ADD;
					{7'b0100000, 3'b000}: ctrl_o.alu_op = SUB;
					{7'b0000000, 3'b111}: ctrl_o.alu_op = AND;
					{7'b0000000, 3'b110}: ctrl_o.alu_op = OR;
					{7'b0000000, 3'b100}: ctrl_o.alu_op = XOR;
					{7'b0000000, 3'b010}: ctrl_o.alu_op = SLT;
					default:              illegal_o = 1'b1;
				endcase
			end
			OP_IMM: begin
				// Only addi
				ctrl_o.use_imm   = 1'b1;
				ctrl_o.reg_write = 1'b1;
				imm_o            = imm_itype;
				illegal_o        = (instr_i.i_fmt.funct3 != 3'b000);
			end
			LOAD: begin
				ctrl_o.use_imm    = 1'b1;
				ctrl_o.mem_read   = 1'b1;
				ctrl_o.reg_write  = 1'b1;
				ctrl_o.mem_to_reg = 1'b1;
				imm_o             = imm_itype;
				illegal_o         = (instr_i.i_fmt.funct3 != 3'b010);
			end
			STORE: begin
				ctrl_o.use_imm   = 1'b1;
				ctrl_o.mem_write = 1'b1;
				imm_o            = imm_stype;
				illegal_o        = (instr_i.s_fmt.funct3 != 3'b010);
			end
			BRANCH: begin
				ctrl_o.alu_op = SUB;
				ctrl_o.branch = 1'b1;
				imm_o         = imm_btype;
				illegal_o     = (instr_i.b_fmt.funct3 != 3'b000);
			end
			JAL: begin
				ctrl_o.jump      = 1'b1;
				ctrl_o.link      = 1'b1;
				ctrl_o.reg_write = 1'b1;
				imm_o            = imm_jtype;
			end
			default: illegal_o = 1'b1;
		endcase
		// Anything not recognised becomes a nop
		if (illegal_o) begin
			ctrl_o = '0;
			imm_o  = '0;
		end
	end

endmodule

// File: logic/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rv_regfile (
	input  logic                clock,
	input  logic                reset,
	input  logic [4:0]          ra_a_i,
	input  logic [4:0]          ra_b_i,
	input  logic [4:0]          wa_i,
	input  logic                wen_i,
	input  logic [`RV_XLEN-1:0] wd_i,
	output logic [`RV_XLEN-1:0] rd_a_o,
	output logic [`RV_XLEN-1:0] rd_b_o
);

	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	// x0 is never written
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && (wa_i != 5'd0)) begin
			regs[wa_i] <= wd_i;
		end
	end

	// Writeback value passes straight to decode in the same cycle
	function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return '0;
		end
		if (wen_i && (wa_i == addr)) begin
			return wd_i;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rd_a_o = read_port(ra_a_i);
		rd_b_o = read_port(ra_b_i);
	end

endmodule

// File: logic/rv_hazard.sv
`timescale 1ns/100ps

module rv_hazard (
	input  logic [4:0] rs1_i,
	input  logic [4:0] rs2_i,
	input  logic       uses_rs2_i,
	input  logic [4:0] idex_rd_i,
	input  logic       idex_mem_read_i,
	input  logic       taken_i,
	input  logic       dmem_stall_i,
	output logic       hold_front_o,
	output logic       bubble_idex_o,
	output logic       flush_front_o,
	output logic       freeze_all_o
);

	logic rs1_match;
	logic rs2_match;
	logic load_use;

	// Load in execute feeding the instruction in decode
	assign rs1_match = (idex_rd_i == rs1_i);
	assign rs2_match = uses_rs2_i && (idex_rd_i == rs2_i);
	assign load_use  = idex_mem_read_i && (idex_rd_i != 5'd0) && (rs1_match || rs2_match);

	// Data stall wins over everything else
	assign freeze_all_o = dmem_stall_i;

	// Taken transfer squashes the two younger slots
	assign flush_front_o = taken_i && !dmem_stall_i;

	// Hold fetch and decode, empty slot into execute
	assign hold_front_o  = load_use && !dmem_stall_i;
	assign bubble_idex_o = load_use && !dmem_stall_i;

endmodule

// File: logic/rv_execute.sv
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rv_execute (
	input  rv_pkg::ctrl_t       ctrl_i,
	input  logic [`RV_XLEN-1:0] pc_i,
	input  logic [`RV_XLEN-1:0] rs1_val_i,
	input  logic [`RV_XLEN-1:0] rs2_val_i,
	input  logic [`RV_XLEN-1:0] imm_i,
	input  logic [4:0]          rs1_i,
	input  logic [4:0]          rs2_i,
	input  logic [4:0]          exmem_rd_i,
	input  logic                exmem_wen_i,
	input  logic [`RV_XLEN-1:0] exmem_val_i,
	input  logic [4:0]          memwb_rd_i,
	input  logic                memwb_wen_i,
	input  logic [`RV_XLEN-1:0] memwb_val_i,
	output logic [`RV_XLEN-1:0] result_o,
	output logic [`RV_XLEN-1:0] store_data_o,
	output logic [`RV_XLEN-1:0] target_o,
	output logic                taken_o
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_b;
	logic [`RV_XLEN-1:0] alu_res;

	// Newest producer first
	function automatic logic [`RV_XLEN-1:0] forward(
		input logic [4:0]          rs,
		input logic [`RV_XLEN-1:0] reg_val
	);
		if (exmem_wen_i && (exmem_rd_i != 5'd0) && (exmem_rd_i == rs)) begin
			return exmem_val_i;
		end
		if (memwb_wen_i && (memwb_rd_i != 5'd0) && (memwb_rd_i == rs)) begin
			return memwb_val_i;
		end
		return reg_val;
	endfunction

	always_comb begin
		op_a = forward(rs1_i, rs1_val_i);
		op_b = forward(rs2_i, rs2_val_i);
	end

	assign alu_b = ctrl_i.use_imm ? imm_i : op_b;

	always_comb begin
		case (ctrl_i.alu_op)
			ADD:     alu_res = op_a + alu_b;
			SUB:     alu_res = op_a - alu_b;
			AND:     alu_res = op_a & alu_b;
			OR:      alu_res = op_a | alu_b;
			XOR:     alu_res = op_a ^ alu_b;
			SLT:     alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_res = '0;
		endcase
	end

	// jal links the return address
	assign result_o     = ctrl_i.link ? pc_i + `RV_XLEN'd4 : alu_res;
	assign store_data_o = op_b;
	assign target_o     = pc_i + imm_i;
	assign taken_o      = ctrl_i.jump || (ctrl_i.branch && (op_a == op_b));

endmodule

// File: logic/rv_pipeline.sv
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rv_pipeline (
	input  logic                clock,
	input  logic                reset,
	output logic [`RV_XLEN-1:0] imem_addr_o,
	input  logic [`RV_XLEN-1:0] imem_data_i,
	output rv_pkg::dmem_req_t   dmem_req_o,
	input  logic [`RV_XLEN-1:0] dmem_rdata_i,
	input  logic                dmem_stall_i,
	output rv_pkg::commit_t     commit_o
);
	import rv_pkg::*;

	typedef struct packed {
		logic                valid;
		logic [`RV_XLEN-1:0] pc;
		rv_instr_u           instr;
	} ifid_t;

	typedef struct packed {
		logic                valid;
		logic [`RV_XLEN-1:0] pc;
		ctrl_t               ctrl;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] rs1_val;
		logic [`RV_XLEN-1:0] rs2_val;
		logic [`RV_XLEN-1:0] imm;
	} idex_t;

	typedef struct packed {
		logic                valid;
		logic [`RV_XLEN-1:0] pc;
		logic                mem_read;
		logic                mem_write;
		logic                reg_write;
		logic                mem_to_reg;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] result;
		logic [`RV_XLEN-1:0] store_data;
	} exmem_t;

	typedef struct packed {
		logic                valid;
		logic [`RV_XLEN-1:0] pc;
		logic                reg_write;
		logic                mem_to_reg;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] alu_result;
		logic [`RV_XLEN-1:0] load_data;
	} memwb_t;

	logic [`RV_XLEN-1:0] pc;
	ifid_t               ifid;
	idex_t               idex;
	exmem_t              exmem;
	memwb_t              memwb;
	ctrl_t               dec_ctrl;
	ctrl_t               id_ctrl;
	logic [`RV_XLEN-1:0] dec_imm;
	logic                dec_illegal;
	logic                uses_rs2;
	logic [`RV_XLEN-1:0] rs1_val;
	logic [`RV_XLEN-1:0] rs2_val;
	logic [`RV_XLEN-1:0] ex_result;
	logic [`RV_XLEN-1:0] ex_store_data;
	logic [`RV_XLEN-1:0] ex_target;
	logic                ex_taken;
	logic                hold_front;
	logic                bubble_idex;
	logic                flush_front;
	logic                freeze_all;
	logic [`RV_XLEN-1:0] wb_data;
	logic                rf_wen;

	// Fetch
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= `RV_RESET_PC;
		end else if (!freeze_all) begin
			if (flush_front) begin
				pc <= ex_target;
			end else if (!hold_front) begin
				pc <= pc + `RV_XLEN'd4;
			end
		end
	end

	assign imem_addr_o = pc;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ifid <= '0;
		end else if (!freeze_all) begin
			if (flush_front) begin
				ifid <= '0;
			end else if (!hold_front) begin
				ifid.valid <= 1'b1;
				ifid.pc    <= pc;
				ifid.instr <= imem_data_i;
			end
		end
	end

	// Decode
	rv_decode u_decode (
		.instr_i   (ifid.instr),
		.ctrl_o    (dec_ctrl),
		.imm_o     (dec_imm),
		.illegal_o (dec_illegal)
	);

	rv_regfile u_regfile (
		.clock  (clock),
		.reset  (reset),
		.ra_a_i (ifid.instr.r_fmt.rs1),
		.ra_b_i (ifid.instr.r_fmt.rs2),
		.wa_i   (memwb.rd),
		.wen_i  (rf_wen),
		.wd_i   (wb_data),
		.rd_a_o (rs1_val),
		.rd_b_o (rs2_val)
	);

	// Empty slots and unknown opcodes carry no control
	always_comb begin
		id_ctrl = dec_ctrl;
		if (!ifid.valid || dec_illegal) begin
			id_ctrl = '0;
		end
	end

	assign uses_rs2 = ifid.instr.r_fmt.opcode inside {OP, STORE, BRANCH};

	rv_hazard u_hazard (
		.rs1_i           (ifid.instr.r_fmt.rs1),
		.rs2_i           (ifid.instr.r_fmt.rs2),
		.uses_rs2_i      (uses_rs2),
		.idex_rd_i       (idex.rd),
		.idex_mem_read_i (idex.ctrl.mem_read),
		.taken_i         (ex_taken),
		.dmem_stall_i    (dmem_stall_i),
		.hold_front_o    (hold_front),
		.bubble_idex_o   (bubble_idex),
		.flush_front_o   (flush_front),
		.freeze_all_o    (freeze_all)
	);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			idex <= '0;
		end else if (!freeze_all) begin
			if (flush_front || bubble_idex) begin
				idex <= '0;
			end else begin
				idex.valid   <= ifid.valid;
				idex.pc      <= ifid.pc;
				idex.ctrl    <= id_ctrl;
				idex.rs1     <= ifid.instr.r_fmt.rs1;
				idex.rs2     <= ifid.instr.r_fmt.rs2;
				// rd is zero whenever nothing gets written
				idex.rd      <= id_ctrl.reg_write ? ifid.instr.r_fmt.rd : 5'd0;
				idex.rs1_val <= rs1_val;
				idex.rs2_val <= rs2_val;
				idex.imm     <= dec_imm;
			end
		end
	end

	// Execute
	rv_execute u_execute (
		.ctrl_i       (idex.ctrl),
		.pc_i         (idex.pc),
		.rs1_val_i    (idex.rs1_val),
		.rs2_val_i    (idex.rs2_val),
		.imm_i        (idex.imm),
		.rs1_i        (idex.rs1),
		.rs2_i        (idex.rs2),
		.exmem_rd_i   (exmem.rd),
		.exmem_wen_i  (exmem.reg_write),
		.exmem_val_i  (exmem.result),
		.memwb_rd_i   (memwb.rd),
		.memwb_wen_i  (memwb.reg_write),
		.memwb_val_i  (wb_data),
		.result_o     (ex_result),
		.store_data_o (ex_store_data),
		.target_o     (ex_target),
		.taken_o      (ex_taken)
	);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			exmem <= '0;
		end else if (!freeze_all) begin
			exmem.valid      <= idex.valid;
			exmem.pc         <= idex.pc;
			exmem.mem_read   <= idex.ctrl.mem_read;
			exmem.mem_write  <= idex.ctrl.mem_write;
			exmem.reg_write  <= idex.ctrl.reg_write;
			exmem.mem_to_reg <= idex.ctrl.mem_to_reg;
			exmem.rd         <= idex.rd;
			exmem.result     <= ex_result;
			exmem.store_data <= ex_store_data;
		end
	end

	// Memory, request held steady by the frozen EX/MEM
	always_comb begin
		dmem_req_o.read  = exmem.valid && exmem.mem_read;
		dmem_req_o.write = exmem.valid && exmem.mem_write;
		dmem_req_o.addr  = exmem.result;
		dmem_req_o.wdata = exmem.store_data;
	end

	// Held contents still feed forwarding while the stall lasts
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			memwb <= '0;
		end else if (freeze_all) begin
			memwb.valid <= 1'b0;
		end else begin
			memwb.valid      <= exmem.valid;
			memwb.pc         <= exmem.pc;
			memwb.reg_write  <= exmem.reg_write;
			memwb.mem_to_reg <= exmem.mem_to_reg;
			memwb.rd         <= exmem.rd;
			memwb.alu_result <= exmem.result;
			memwb.load_data  <= dmem_rdata_i;
		end
	end

	// Writeback
	assign wb_data = memwb.mem_to_reg ? memwb.load_data : memwb.alu_result;
	assign rf_wen  = memwb.valid && memwb.reg_write;

	always_comb begin
		commit_o.valid = memwb.valid;
		commit_o.pc    = memwb.pc;
		commit_o.rd    = memwb.rd;
		commit_o.data  = memwb.reg_write ? wb_data : '0;
	end

endmodule

// File: logic/rv_core_top.sv
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rv_core_top (
	input  logic                clock,
	input  logic                reset,
	// Instruction fetch, combinational return
	output logic [`RV_XLEN-1:0] imem_addr_o,
	input  logic [`RV_XLEN-1:0] imem_data_i,
	// Data memory
	output rv_pkg::dmem_req_t   dmem_req_o,
	input  logic [`RV_XLEN-1:0] dmem_rdata_i,
	input  logic                dmem_stall_i,
	// Retirement trace
	output rv_pkg::commit_t     commit_o
);

	rv_pipeline u_pipeline (
		.clock        (clock),
		.reset        (reset),
		.imem_addr_o  (imem_addr_o),
		.imem_data_i  (imem_data_i),
		.dmem_req_o   (dmem_req_o),
		.dmem_rdata_i (dmem_rdata_i),
		.dmem_stall_i (dmem_stall_i),
		.commit_o     (commit_o)
	);

endmodule

// File: sim/rv_core_props.sv
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rv_core_props (
	input logic                clock,
	input logic                reset,
	input rv_pkg::commit_t     commit_i,
	input rv_pkg::dmem_req_t   dmem_req_i,
	input logic                dmem_stall_i,
	input logic                flush_i,
	input logic [`RV_XLEN-1:0] flush_pc_i
);

	int unsigned         fail_count = 0;
	logic                squash_seen;
	logic [`RV_XLEN-1:0] squash_pc_a;
	logic [`RV_XLEN-1:0] squash_pc_b;

	// Addresses of the two slots behind the latest taken transfer
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			squash_seen <= 1'b0;
			squash_pc_a <= '0;
			squash_pc_b <= '0;
		end else if (flush_i) begin
			squash_seen <= 1'b1;
			squash_pc_a <= flush_pc_i + 32'd4;
			squash_pc_b <= flush_pc_i + 32'd8;
		end
	end

	no_commit_after_reset: assert property (@(posedge clock)
		$rose(reset) |-> !commit_i.valid)
	else begin
		$error("commit valid in the first cycle after reset");
		fail_count++;
	end

	read_write_exclusive: assert property (@(posedge clock) disable iff (!reset)
		!(dmem_req_i.read && dmem_req_i.write))
	else begin
		$error("data memory read and write requested together");
		fail_count++;
	end

	req_stable_in_stall: assert property (@(posedge clock) disable iff (!reset)
		dmem_stall_i |=> $stable(dmem_req_i))
	else begin
		$error("data memory request changed while stalled");
		fail_count++;
	end

	no_squashed_commit: assert property (@(posedge clock) disable iff (!reset)
		(commit_i.valid && squash_seen) |->
			((commit_i.pc != squash_pc_a) && (commit_i.pc != squash_pc_b)))
	else begin
		$error("squashed instruction at pc %h committed", commit_i.pc);
		fail_count++;
	end

endmodule

bind rv_core_top rv_core_props u_props (
	.clock        (clock),
	.reset        (reset),
	.commit_i     (commit_o),
	.dmem_req_i   (dmem_req_o),
	.dmem_stall_i (dmem_stall_i),
	.flush_i      (u_pipeline.flush_front),
	.flush_pc_i   (u_pipeline.idex.pc)
);

// File: sim/tb_rv_core.sv
`timescale 1ns/100ps
`include "rv_cfg.svh"

module tb_rv_core;
	import rv_pkg::*;

	localparam int          CLK_PERIOD      = 8;
	localparam int          RESET_CYCLES    = 5;
	localparam int          PROG_LEN        = 34;
	localparam int          DMEM_WORDS      = 256;
	localparam int          SEED            = 64576;
	localparam logic [31:0] NOP             = 32'h0000_0013;
	localparam logic [31:0] HALT_PC         = `RV_RESET_PC + 4 * (PROG_LEN - 1);
	localparam int          WATCHDOG_CYCLES = 40 * PROG_LEN + RESET_CYCLES;

	logic        clock;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] imem_word;
	dmem_req_t   dmem_req;
	logic [31:0] dmem_rdata;
	logic        dmem_stall;
	commit_t     commit;

	logic [31:0] rom [PROG_LEN];
	logic [31:0] ram [DMEM_WORDS];
	logic [31:0] ref_regs [32];
	logic [31:0] ref_mem [DMEM_WORDS];
	logic [31:0] ref_pc;
	int          errors;
	int          commits;
	logic        done;

	rv_core_top UUT (
		.clock        (clock),
		.reset        (reset),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.dmem_req_o   (dmem_req),
		.dmem_rdata_i (dmem_rdata),
		.dmem_stall_i (dmem_stall),
		.commit_o     (commit)
	);

	// Instruction encoders
	function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [31:0] imm);
		return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [31:0] imm);
		return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [31:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [31:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [31:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Background data, different at every byte address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'hA5A5_5A5A;
	endfunction

	task automatic load_program();
		rom[0]  = addi_word(5'd1, 5'd0, 32'd5);
		rom[1]  = addi_word(5'd2, 5'd0, -32'sd3);
		rom[2]  = op_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
		rom[3]  = op_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
		rom[4]  = op_word(7'h00, 3'b111, 5'd5, 5'd4, 5'd2);
		rom[5]  = op_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd3);
		rom[6]  = op_word(7'h00, 3'b100, 5'd7, 5'd6, 5'd1);
		rom[7]  = op_word(7'h00, 3'b010, 5'd8, 5'd2, 5'd1);
		rom[8]  = op_word(7'h00, 3'b010, 5'd9, 5'd1, 5'd2);
		rom[9]  = addi_word(5'd10, 5'd0, 32'd64);
		rom[10] = store_word(5'd7, 5'd10, 32'd0);
		rom[11] = load_word(5'd11, 5'd10, 32'd0);
		// Load followed directly by its consumer
		rom[12] = op_word(7'h00, 3'b000, 5'd12, 5'd11, 5'd1);
		rom[13] = store_word(5'd12, 5'd10, 32'd4);
		rom[14] = load_word(5'd13, 5'd10, 32'd4);
		rom[15] = addi_word(5'd0, 5'd13, 32'd7);
		rom[16] = op_word(7'h00, 3'b000, 5'd14, 5'd0, 5'd13);
		rom[17] = beq_word(5'd1, 5'd2, 32'd12);
		rom[18] = addi_word(5'd15, 5'd0, 32'd1);
		rom[19] = beq_word(5'd15, 5'd15, 32'd12);
		rom[20] = addi_word(5'd16, 5'd0, 32'd99);
		rom[21] = addi_word(5'd17, 5'd0, 32'd98);
		rom[22] = jal_word(5'd18, 32'd12);
		rom[23] = addi_word(5'd16, 5'd0, 32'd77);
		rom[24] = addi_word(5'd17, 5'd0, 32'd76);
		rom[25] = op_word(7'h00, 3'b000, 5'd19, 5'd18, 5'd15);
		rom[26] = load_word(5'd20, 5'd10, 32'd0);
		rom[27] = store_word(5'd20, 5'd10, 32'd8);
		rom[28] = load_word(5'd21, 5'd10, 32'd8);
		rom[29] = beq_word(5'd21, 5'd7, 32'd12);
		rom[30] = addi_word(5'd22, 5'd0, 32'd55);
		rom[31] = addi_word(5'd23, 5'd0, 32'd56);
		rom[32] = op_word(7'h00, 3'b100, 5'd24, 5'd21, 5'd20);
		// Halt loop
		rom[33] = jal_word(5'd0, 32'd0);
	endtask

	// Architectural model, one instruction per call
	function automatic commit_t ref_step();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] next_pc;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		commit_t     rec;
		ins   = rom[(ref_pc - `RV_RESET_PC) >> 2];
		a     = ref_regs[ins[19:15]];
		b     = ref_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		rec       = '0;
		rec.valid = 1'b1;
		rec.pc    = ref_pc;
		next_pc   = ref_pc + 32'd4;
		case (ins[6:0])
			7'b0110011: begin
				rec.rd = ins[11:7];
				case ({ins[30], ins[14:12]})
					4'b0000: rec.data = a + b;
					4'b1000: rec.data = a - b;
					4'b0111: rec.data = a & b;
					4'b0110: rec.data = a | b;
					4'b0100: rec.data = a ^ b;
					4'b0010: rec.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: rec.data = 'x;
				endcase
			end
			7'b0010011: begin
				rec.rd   = ins[11:7];
				rec.data = a + imm_i;
			end
			7'b0000011: begin
				addr     = a + imm_i;
				rec.rd   = ins[11:7];
				rec.data = ref_mem[addr[9:2]];
			end
			7'b0100011: begin
				addr               = a + imm_s;
				ref_mem[addr[9:2]] = b;
			end
			7'b1100011: begin
				if (a == b) begin
					next_pc = ref_pc + imm_b;
				end
			end
			7'b1101111: begin
				rec.rd   = ins[11:7];
				rec.data = ref_pc + 32'd4;
				next_pc  = ref_pc + imm_j;
			end
			default: begin
				rec.data = '0;
			end
		endcase
		// x0 shows the computed value on commit but keeps reading zero
		if (rec.rd != 5'd0) begin
			ref_regs[rec.rd] = rec.data;
		end
		ref_pc = next_pc;
		return rec;
	endfunction

	task automatic check_memory();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			if (ram[i] !== ref_mem[i]) begin
				$display("FAILED at %0t ns: ram[%0d] = %h, expected %h",
					$time, i, ram[i], ref_mem[i]);
				errors++;
			end
		end
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = UUT.u_props.fail_count;
		$display("Summary: %0d commits checked, %0d check errors, %0d assertion failures",
			commits, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	// Memory models, both answer within the same cycle
	assign imem_word  = (imem_addr - `RV_RESET_PC) >> 2;
	assign imem_data  = (imem_word < PROG_LEN) ? rom[imem_word] : NOP;
	// Read data only while a read is requested
	assign dmem_rdata = dmem_req.read ? ram[dmem_req.addr[9:2]] : 'x;

	always @(posedge clock) begin
		if (dmem_req.write && !dmem_stall) begin
			ram[dmem_req.addr[9:2]] <= dmem_req.wdata;
		end
	end

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Stall in roughly one cycle of four
	initial begin
		void'($urandom(SEED));
		dmem_stall = 1'b0;
		forever begin
			@(posedge clock);
			if (!reset) begin
				dmem_stall <= 1'b0;
			end else begin
				dmem_stall <= (($urandom % 4) == 0);
			end
		end
	end

	// Commit stream against the model, sampled mid cycle
	always @(negedge clock) begin
		commit_t expected;
		if (reset && commit.valid && !done) begin
			expected = ref_step();
			if (commit.pc !== expected.pc) begin
				$display("FAILED at %0t ns: commit_o.pc = %h, expected %h",
					$time, commit.pc, expected.pc);
				errors++;
			end
			if (commit.rd !== expected.rd) begin
				$display("FAILED at %0t ns: commit_o.rd = %0d, expected %0d",
					$time, commit.rd, expected.rd);
				errors++;
			end
			if (commit.data !== expected.data) begin
				$display("FAILED at %0t ns: commit_o.data = %h, expected %h",
					$time, commit.data, expected.data);
				errors++;
			end
			commits++;
			if (expected.pc == HALT_PC) begin
				done = 1'b1;
			end
		end
	end

	initial begin
		reset   = 1'b0;
		errors  = 0;
		commits = 0;
		done    = 1'b0;
		ref_pc  = `RV_RESET_PC;
		load_program();
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			ram[i]     = fill_word(4 * i);
			ref_mem[i] = fill_word(4 * i);
		end
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b1;
		wait (done);
		@(posedge clock);
		check_memory();
		finish_run();
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the final instruction at pc %h never committed, %0d commits seen",
			HALT_PC, commits);
		errors++;
		finish_run();
	end

endmodule

// File: verilog.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_hazard.sv
logic/rv_execute.sv
logic/rv_pipeline.sv
logic/rv_core_top.sv
sim/rv_core_props.sv
sim/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_pkg.sv
      - logic/rv_decode.sv
      - logic/rv_regfile.sv
      - logic/rv_hazard.sv
      - logic/rv_execute.sv
      - logic/rv_pipeline.sv
      - logic/rv_core_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/rv_core_props.sv
      - sim/tb_rv_core.sv
